// ==== hw/fixp_pkg.sv ====
package fixp_pkg;

    // ~~~~~~~~~~ Q8.8 format ~~~~~~~~~~

    localparam int Q88_W     = 16;          // total bits per value
    localparam int FRAC_BITS = 8;           // bits right of the point
    localparam int PROD_W    = 2 * Q88_W;   // full signed product

    typedef logic signed [Q88_W-1:0]  q88_t;
    typedef logic signed [PROD_W-1:0] prod_t;

    // ~~~~~~~~~~ saturation ~~~~~~~~~~

    localparam q88_t Q88_MAX = 16'h7FFF;    // just under +128.0
    localparam q88_t Q88_MIN = 16'h8000;    // -128.0

    // half a result lsb goes in ahead of the shift so ties round up
    localparam prod_t ROUND_HALF = prod_t'(1) << (FRAC_BITS - 1);

endpackage

// ==== hw/stream_pkg.sv ====
package stream_pkg;

    // ~~~~~~~~~~ beat geometry ~~~~~~~~~~

    localparam int LANE_W      = 64;                    // one tap word
    localparam int CH_PER_LANE = 4;                     // channels in a tap word
    localparam int CH_W        = LANE_W / CH_PER_LANE;  // bits per channel

    // channel 0 sits in the low bits, channel 3 at the top
    typedef logic [LANE_W-1:0] lane_t;

endpackage

// ==== hw/q88_multiplier.sv ====
`timescale 1ns/100ps

module q88_multiplier
(
    input  fixp_pkg::q88_t a,
    input  fixp_pkg::q88_t b,
    output fixp_pkg::q88_t p
);

    fixp_pkg::prod_t prod;
    fixp_pkg::prod_t rounded;
    fixp_pkg::prod_t shifted;

    assign prod    = fixp_pkg::prod_t'(a) * fixp_pkg::prod_t'(b);   // Q16.16
    assign rounded = prod + fixp_pkg::ROUND_HALF;
    assign shifted = rounded >>> fixp_pkg::FRAC_BITS;                // back to Q.8

    always_comb
    begin
        if (shifted > fixp_pkg::Q88_MAX)
        begin
            p = fixp_pkg::Q88_MAX;
        end
        else if (shifted < fixp_pkg::Q88_MIN)
        begin
            p = fixp_pkg::Q88_MIN;
        end
        else
        begin
            p = shifted[fixp_pkg::Q88_W-1:0];
        end
    end

endmodule

// ==== hw/weight_buffer.sv ====
`timescale 1ns/100ps

module weight_buffer #(
    parameter int N_TAPS = 9
)
(
    input  logic                                aclk,
    input  logic                                rst_n,
    input  stream_pkg::lane_t                   s_axis_w_tdata,
    input  logic                                s_axis_w_tvalid,
    input  logic                                s_axis_w_tlast,
    input  logic                                frame_open,
    output logic                                s_axis_w_tready,
    output logic [N_TAPS*stream_pkg::LANE_W-1:0] weight_taps,
    output logic                                weights_valid,
    output logic                                weights_busy
);

    localparam int IDX_W = (N_TAPS > 1) ? $clog2(N_TAPS) : 1;

    stream_pkg::lane_t taps [N_TAPS];
    logic [IDX_W-1:0]  tap_idx;
    logic              w_fire;
    logic              frame_end;

    assign s_axis_w_tready = ~frame_open;                 // no reload inside an input frame
    assign w_fire          = s_axis_w_tvalid & s_axis_w_tready;
    assign frame_end       = s_axis_w_tlast | (tap_idx == IDX_W'(N_TAPS - 1));
    assign weights_busy    = (tap_idx != '0);

    // ~~~~~~~~~~ write index ~~~~~~~~~~

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            tap_idx       <= '0;
            weights_valid <= 1'b0;
        end
        else if (w_fire)
        begin
            if (frame_end)
            begin
                tap_idx       <= '0;
                weights_valid <= 1'b1;                    // sticky once a frame lands
            end
            else
            begin
                tap_idx <= tap_idx + 1'b1;
            end
        end
    end

    // ~~~~~~~~~~ tap storage ~~~~~~~~~~

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            taps <= '{default: '0};                       // taps start at zero
        end
        else if (w_fire)
        begin
            taps[tap_idx] <= s_axis_w_tdata;              // short frames leave the rest alone
        end
    end

    for (genvar t = 0; t < N_TAPS; t++)
    begin : g_flat
        assign weight_taps[t*stream_pkg::LANE_W +: stream_pkg::LANE_W] = taps[t];
    end

endmodule

// ==== hw/product_pipeline.sv ====
`timescale 1ns/100ps

module product_pipeline #(
    parameter int N_TAPS = 9
)
(
    input  logic                                aclk,
    input  logic                                rst_n,
    input  logic [N_TAPS*stream_pkg::LANE_W-1:0] in_data,
    input  logic                                in_valid,
    input  logic                                in_last,
    input  logic [N_TAPS*stream_pkg::LANE_W-1:0] weight_taps,
    input  logic                                m_axis_tready,
    output logic                                in_ready,
    output logic [N_TAPS*stream_pkg::LANE_W-1:0] m_axis_tdata,
    output logic                                m_axis_tvalid,
    output logic                                m_axis_tlast
);

    localparam int BEAT_W = N_TAPS * stream_pkg::LANE_W;

    logic              s1_valid;
    logic [BEAT_W-1:0] s1_data;
    logic              s1_last;
    logic              s2_valid;
    logic [BEAT_W-1:0] s2_data;
    logic              s2_last;
    logic              s2_free;
    logic [BEAT_W-1:0] prod_beat;

    fixp_pkg::q88_t prod [N_TAPS][stream_pkg::CH_PER_LANE];

    assign s2_free  = ~s2_valid | m_axis_tready;          // stage 2 empty or draining
    assign in_ready = ~s1_valid | s2_free;

    // ~~~~~~~~~~ stage 1 ~~~~~~~~~~

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            s1_valid <= 1'b0;
        end
        else if (in_ready)
        begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (in_valid && in_ready)
        begin
            s1_data <= in_data;
            s1_last <= in_last;
        end
    end

    // ~~~~~~~~~~ multipliers ~~~~~~~~~~

    for (genvar t = 0; t < N_TAPS; t++)
    begin : g_tap
        for (genvar c = 0; c < stream_pkg::CH_PER_LANE; c++)
        begin : g_ch
            localparam int LSB = t * stream_pkg::LANE_W + c * stream_pkg::CH_W;

            q88_multiplier u_mul
            (
                .a(s1_data[LSB +: stream_pkg::CH_W]),
                .b(weight_taps[LSB +: stream_pkg::CH_W]),    // same tap, same channel
                .p(prod[t][c])
            );

            assign prod_beat[LSB +: stream_pkg::CH_W] = prod[t][c];
        end
    end

    // ~~~~~~~~~~ stage 2 ~~~~~~~~~~

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            s2_valid <= 1'b0;
        end
        else if (s2_free)
        begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (s2_free && s1_valid)
        begin
            s2_data <= prod_beat;                         // weights sampled here
            s2_last <= s1_last;
        end
    end

    assign m_axis_tdata  = s2_data;
    assign m_axis_tvalid = s2_valid;
    assign m_axis_tlast  = s2_last;

endmodule

// ==== hw/axis_top.sv ====
`timescale 1ns/100ps

module axis_top #(
    parameter int N_TAPS = 9
)
(
    input  logic                                aclk,
    input  logic                                rst_n,

    input  stream_pkg::lane_t                   s_axis_w_tdata,
    input  logic                                s_axis_w_tvalid,
    input  logic                                s_axis_w_tlast,
    output logic                                s_axis_w_tready,

    input  logic [N_TAPS*stream_pkg::LANE_W-1:0] s_axis_i_tdata,
    input  logic                                s_axis_i_tvalid,
    input  logic                                s_axis_i_tlast,
    output logic                                s_axis_i_tready,

    output logic [N_TAPS*stream_pkg::LANE_W-1:0] m_axis_tdata,
    output logic                                m_axis_tvalid,
    output logic                                m_axis_tlast,
    input  logic                                m_axis_tready
);

    logic [N_TAPS*stream_pkg::LANE_W-1:0] weight_taps;
    logic                                weights_valid;
    logic                                weights_busy;
    logic                                frame_open;
    logic                                take_ok;
    logic                                pipe_ready;
    logic                                i_fire;

    // inputs wait for a complete weight frame with no reload under way
    assign take_ok         = weights_valid & ~weights_busy;
    assign s_axis_i_tready = pipe_ready & take_ok;
    assign i_fire          = s_axis_i_tvalid & s_axis_i_tready;

    always_ff @(posedge aclk)
    begin
        if (!rst_n)
        begin
            frame_open <= 1'b0;
        end
        else if (i_fire)
        begin
            frame_open <= ~s_axis_i_tlast;                // open until the closing beat
        end
    end

    weight_buffer #(
        .N_TAPS(N_TAPS)
    ) u_weights
    (
        .aclk           (aclk),
        .rst_n          (rst_n),
        .s_axis_w_tdata (s_axis_w_tdata),
        .s_axis_w_tvalid(s_axis_w_tvalid),
        .s_axis_w_tlast (s_axis_w_tlast),
        .frame_open     (frame_open),
        .s_axis_w_tready(s_axis_w_tready),
        .weight_taps    (weight_taps),
        .weights_valid  (weights_valid),
        .weights_busy   (weights_busy)
    );

    product_pipeline #(
        .N_TAPS(N_TAPS)
    ) u_pipe
    (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .in_data      (s_axis_i_tdata),
        .in_valid     (s_axis_i_tvalid & take_ok),
        .in_last      (s_axis_i_tlast),
        .weight_taps  (weight_taps),
        .m_axis_tready(m_axis_tready),
        .in_ready     (pipe_ready),
        .m_axis_tdata (m_axis_tdata),
        .m_axis_tvalid(m_axis_tvalid),
        .m_axis_tlast (m_axis_tlast)
    );

endmodule

// ==== testbench/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ~~~~~~~~~~ reference model ~~~~~~~~~~

function automatic fixp_pkg::q88_t ref_q88(input fixp_pkg::q88_t a, input fixp_pkg::q88_t b);
    longint full;
    full = longint'(a) * longint'(b);
    full = (full + 128) >>> fixp_pkg::FRAC_BITS;      // round half up
    if (full > 32767)
        return 16'h7FFF;
    else if (full < -32768)
        return 16'h8000;
    return fixp_pkg::q88_t'(full);
endfunction

// every channel of every tap against the weights the DUT should hold
function automatic logic [BEAT_W-1:0] ref_beat(input logic [BEAT_W-1:0] d);
    logic [BEAT_W-1:0] r;
    int                lsb;
    for (int t = 0; t < N_TAPS; t++)
    begin
        for (int c = 0; c < stream_pkg::CH_PER_LANE; c++)
        begin
            lsb = t * stream_pkg::LANE_W + c * 16;
            r[lsb +: 16] = ref_q88(d[lsb +: 16], w_model[t][c*16 +: 16]);
        end
    end
    return r;
endfunction

// ~~~~~~~~~~ compare tasks ~~~~~~~~~~

task check_beat(input logic [BEAT_W-1:0] expected, input logic [BEAT_W-1:0] actual);
    if (actual !== expected)
    begin
        $display("Error in %s: beat expected %h, actual %h", test_name, expected, actual);
        report_failure();
    end
endtask

task check_last(input logic expected, input logic actual);
    if (actual !== expected)
    begin
        $display("Error in %s: tlast expected %b, actual %b", test_name, expected, actual);
        report_failure();
    end
endtask

task check_q88(input fixp_pkg::q88_t expected, input fixp_pkg::q88_t actual);
    if (actual !== expected)
    begin
        $display("Error in %s: channel expected %h, actual %h", test_name, expected, actual);
        report_failure();
    end
endtask

task check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected)
    begin
        $display("Error in %s: %s expected %b, actual %b", test_name, what, expected, actual);
        report_failure();
    end
endtask

task check_cycles(input int expected, input int actual);
    if (actual != expected)
    begin
        $display("Error in %s: latency expected %0d, actual %0d", test_name, expected, actual);
        report_failure();
    end
endtask

`endif

// ==== testbench/tb_axis_top.sv ====
`timescale 1ns/100ps

module tb_axis_top;

    localparam int N_TAPS      = 9;
    localparam int BEAT_W      = N_TAPS * stream_pkg::LANE_W;
    localparam int TOTAL_BEATS = 66;                      // weight beats, input beats, idle cycles
    localparam int TIMEOUT_NS  = 20 * TOTAL_BEATS * 10;

    logic              aclk = 1'b0;
    logic              rst_n;
    stream_pkg::lane_t s_axis_w_tdata;
    logic              s_axis_w_tvalid;
    logic              s_axis_w_tlast;
    logic              s_axis_w_tready;
    logic [BEAT_W-1:0] s_axis_i_tdata;
    logic              s_axis_i_tvalid;
    logic              s_axis_i_tlast;
    logic              s_axis_i_tready;
    logic [BEAT_W-1:0] m_axis_tdata;
    logic              m_axis_tvalid;
    logic              m_axis_tlast;
    logic              m_axis_tready;

    stream_pkg::lane_t w_model [N_TAPS];                  // taps the DUT should hold
    stream_pkg::lane_t w_frame [N_TAPS];
    logic [BEAT_W-1:0] exp_beats [$];
    logic              exp_lasts [$];
    int                acc_cycle [$];
    logic [BEAT_W-1:0] last_out;
    string             test_name = "reset";
    logic [15:0]       lfsr_state = 16'd33;
    int                cycle = 0;
    int                lat_start;
    logic              in_frame = 1'b0;
    logic              stall_mode = 1'b0;
    logic              check_latency = 1'b0;

    axis_top #(.N_TAPS(N_TAPS)) dut0 (.*);

    always #5 aclk = ~aclk;

    task report_failure();
        $display("Something failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // 16 bit fibonacci lfsr on taps 16 14 13 11
    function logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
            r = {r[62:0], lfsr_bit()};
        return r;
    endfunction

    function stream_pkg::lane_t small_lane();
        stream_pkg::lane_t w;
        logic [9:0]        r;
        for (int c = 0; c < stream_pkg::CH_PER_LANE; c++)
        begin
            r = 10'(rand_bits(10));
            w[c*16 +: 16] = {{6{r[9]}}, r};                // about +-2.0
        end
        return w;
    endfunction

    `include "tb_checks.svh"

    // ~~~~~~~~~~ monitor ~~~~~~~~~~

    always @(posedge aclk)
    begin
        if (rst_n)
        begin
            if (in_frame)
                check_flag("s_axis_w_tready inside an input frame", 1'b0, s_axis_w_tready);
            if (s_axis_i_tvalid && s_axis_i_tready)
            begin
                exp_beats.push_back(ref_beat(s_axis_i_tdata));
                exp_lasts.push_back(s_axis_i_tlast);
                acc_cycle.push_back(cycle);
                in_frame = ~s_axis_i_tlast;
            end
            if (m_axis_tvalid && m_axis_tready && exp_beats.size() == 0)
            begin
                $display("Error in %s: the DUT sent a beat that no input produced", test_name);
                report_failure();
            end
            else if (m_axis_tvalid && m_axis_tready)
            begin
                lat_start = acc_cycle.pop_front();
                check_beat(exp_beats.pop_front(), m_axis_tdata);
                check_last(exp_lasts.pop_front(), m_axis_tlast);
                if (check_latency)
                    check_cycles(2, cycle - lat_start);
                last_out = m_axis_tdata;
            end
        end
        cycle++;
    end

    // ~~~~~~~~~~ stimulus ~~~~~~~~~~

    task step();
        @(negedge aclk);
        m_axis_tready = stall_mode ? lfsr_bit() : 1'b1;
    endtask

    task send_weights(input int n);
        for (int i = 0; i < n; i++)
        begin
            s_axis_w_tdata  = w_frame[i];
            s_axis_w_tlast  = (i == n - 1);
            s_axis_w_tvalid = 1'b1;
            #1;
            while (!s_axis_w_tready)
            begin
                step();
                #1;
            end
            step();
            w_model[i] = w_frame[i];                      // stored on the accepting edge
        end
        s_axis_w_tvalid = 1'b0;
        s_axis_w_tlast  = 1'b0;
    endtask

    task push_input(input logic [BEAT_W-1:0] d, input logic last);
        s_axis_i_tdata  = d;
        s_axis_i_tlast  = last;
        s_axis_i_tvalid = 1'b1;
        #1;
        while (!s_axis_i_tready)
        begin
            step();
            #1;
        end
        step();
        s_axis_i_tvalid = 1'b0;
    endtask

    task send_frame(input int n, input logic ovf);
        logic [BEAT_W-1:0] d;
        for (int b = 0; b < n; b++)
        begin
            for (int t = 0; t < N_TAPS; t++)
                d[t*stream_pkg::LANE_W +: stream_pkg::LANE_W] = rand_bits(64);
            if (ovf && b == n - 1)
                d[31:0] = {16'hC000, 16'h4000};           // -64.0 and +64.0
            push_input(d, b == n - 1);
        end
    endtask

    task wait_drain();
        while (exp_beats.size() != 0 || m_axis_tvalid)
            step();
    endtask

    // ~~~~~~~~~~ tests ~~~~~~~~~~

    task test_idle_after_reset();
        test_name = "idle_after_reset";
        s_axis_i_tvalid = 1'b1;                           // offered before any weights
        repeat (8)
        begin
            #1;
            check_flag("s_axis_i_tready", 1'b0, s_axis_i_tready);
            check_flag("s_axis_w_tready", 1'b1, s_axis_w_tready);
            check_flag("m_axis_tvalid", 1'b0, m_axis_tvalid);
            step();
        end
        s_axis_i_tvalid = 1'b0;
    endtask

    task test_unit_weights();
        test_name = "unit_weights";
        for (int t = 0; t < N_TAPS; t++)
            w_frame[t] = {4{16'h0100}};
        send_weights(N_TAPS);
        send_frame(8, 1'b0);
        wait_drain();
    endtask

    task test_random_weights();
        test_name = "random_weights";
        for (int t = 0; t < N_TAPS; t++)
            w_frame[t] = small_lane();
        w_frame[0][31:0] = {16'h7F00, 16'h7F00};         // 127.0 so the last beat clamps
        send_weights(N_TAPS);
        send_frame(6, 1'b1);
        wait_drain();
        check_q88(16'h7FFF, last_out[15:0]);
        check_q88(16'h8000, last_out[31:16]);
    endtask

    task test_short_weight_frame();
        test_name = "short_weight_frame";
        for (int t = 0; t < 3; t++)
            w_frame[t] = small_lane();
        send_weights(3);                                  // taps 3 and up keep old values
        send_frame(6, 1'b0);
        wait_drain();
    endtask

    task test_output_stall();
        test_name = "output_stall";
        stall_mode = 1'b1;
        send_frame(6, 1'b0);
        send_frame(6, 1'b0);
        wait_drain();
        stall_mode = 1'b0;
    endtask

    task test_latency();
        test_name = "latency";
        m_axis_tready = 1'b1;
        check_latency = 1'b1;
        send_frame(5, 1'b0);
        wait_drain();
        check_latency = 1'b0;
    endtask

    initial
    begin
        #(TIMEOUT_NS + 100);
        $display("Error: watchdog expired during %s, the DUT stopped handshaking", test_name);
        report_failure();
    end

    initial
    begin
        rst_n           = 1'b0;
        s_axis_w_tdata  = '0;
        s_axis_w_tvalid = 1'b0;
        s_axis_w_tlast  = 1'b0;
        s_axis_i_tdata  = '0;
        s_axis_i_tvalid = 1'b0;
        s_axis_i_tlast  = 1'b0;
        m_axis_tready   = 1'b1;
        w_model         = '{default: '0};                 // taps come out of reset at zero
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        test_idle_after_reset();
        test_unit_weights();
        test_random_weights();
        test_short_weight_frame();
        test_output_stall();
        test_latency();
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+testbench
hw/fixp_pkg.sv
hw/stream_pkg.sv
hw/q88_multiplier.sv
hw/weight_buffer.sv
hw/product_pipeline.sv
hw/axis_top.sv
testbench/tb_axis_top.sv
